// File: hw/slam_cache_pkg.sv
`default_nettype none

package slam_cache_pkg;

  localparam int FXP_W     = 32;
  localparam int FRAC_BITS = 19;
  localparam int NUM_LANES = 4;
  localparam int SEQ_W     = 5;

  // Q12.19 signed word
  typedef logic signed [FXP_W-1:0] fxp_t;

  // lane 0 sits in the low bits
  typedef logic [NUM_LANES*FXP_W-1:0] lane_vec_t;

  typedef logic [SEQ_W-1:0] seq_cnt_t;

  localparam fxp_t FXP_ONE   = 32'sh0008_0000;
  localparam fxp_t NOISE_Q11 = FXP_ONE;  // measurement noise on S diagonal
  localparam fxp_t NOISE_Q22 = FXP_ONE;

  // B cache input modes
  typedef enum logic [3:0] {
    idle      = 4'd0,
    wr_cov_ht = 4'd8,
    wr_h_lv_h = 4'd9,
    wr_inv    = 4'd10,
    wr_chi    = 4'd11,
    wr_nl_prd = 4'd12,
    wr_nl_upd = 4'd15
  } cache_sel_t;

  // innovation covariance reader FSM
  typedef enum logic [1:0] {
    inv_idle,
    inv_read,
    inv_divide
  } inv_state_t;

  localparam int NUM_DIV = 3;

  // 32 magnitude bits plus the 19 bit fraction shift
  localparam int DIV_STEPS = FXP_W + FRAC_BITS;

  localparam int STEP_CNT_W = $clog2(DIV_STEPS);

endpackage

`default_nettype wire

// File: hw/innov_cov_reader.sv
`default_nettype none

module innov_cov_reader import slam_cache_pkg::*; (
  input  wire logic      clk,
  input  wire logic      sys_rst,
  input  wire logic      init_inv,
  input  wire lane_vec_t c_din,
  output logic           div_start,
  output fxp_t           div_dividend [NUM_DIV],
  output fxp_t           div_divisor
);

  inv_state_t state;
  logic [2:0] rd_cnt;

  fxp_t c_lane0;
  fxp_t c_lane1;
  fxp_t s22_in;

  fxp_t s11;
  fxp_t s21;
  fxp_t s22;
  fxp_t p21_21;
  fxp_t p11_22;
  fxp_t det;

  fxp_t                      mul_a;
  fxp_t                      mul_b;
  logic signed [2*FXP_W-1:0] mul_full;
  fxp_t                      mul_c;

  assign c_lane0 = c_din[0 +: FXP_W];
  assign c_lane1 = c_din[FXP_W +: FXP_W];
  assign s22_in  = c_lane1 + NOISE_Q22;

  // shared multiplier, operands registered one cycle ahead
  assign mul_full = mul_a * mul_b;
  assign mul_c    = mul_full[FRAC_BITS +: FXP_W];

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state     <= inv_idle;
      rd_cnt    <= '0;
      div_start <= 1'b0;
    end else begin
      div_start <= 1'b0;
      case (state)
        inv_idle: begin
          rd_cnt <= '0;
          if (init_inv) begin
            state <= inv_read;
          end
        end
        inv_read: begin
          rd_cnt <= rd_cnt + 3'd1;
          if (rd_cnt == 3'd6) begin  // det is written this cycle
            state <= inv_divide;
          end
        end
        inv_divide: begin
          div_start <= 1'b1;
          state     <= inv_idle;
        end
        default: state <= inv_idle;
      endcase
    end
  end

  // S arrives on the C cache word at fixed offsets from init_inv
  always_ff @(posedge clk) begin
    if (state == inv_read) begin
      case (rd_cnt)
        3'd1: s11 <= c_lane0 + NOISE_Q11;
        3'd2: begin
          s21   <= c_lane1;
          mul_a <= c_lane1;
          mul_b <= c_lane1;
        end
        3'd3: p21_21 <= mul_c;
        3'd4: begin
          s22   <= s22_in;
          mul_a <= s11;
          mul_b <= s22_in;
        end
        3'd5: p11_22 <= mul_c;
        3'd6: det <= p11_22 - p21_21;
        default: ;
      endcase
    end
  end

  // adjugate over det
  always_ff @(posedge clk) begin
    if (state == inv_divide) begin
      div_dividend[0] <= s22;
      div_dividend[1] <= -s21;
      div_dividend[2] <= s11;
      div_divisor     <= det;
    end
  end

  a_init_idle: assert property (@(posedge clk) disable iff (sys_rst)
    init_inv |-> state == inv_idle)
    else $warning("init_inv while the inverse is still being read");

  a_det_nonzero: assert property (@(posedge clk) disable iff (sys_rst)
    div_start |-> div_divisor != '0)
    else $error("singular innovation covariance");

endmodule

`default_nettype wire

// File: hw/fxp_divider.sv
`default_nettype none

module fxp_divider import slam_cache_pkg::*; (
  input  wire logic clk,
  input  wire logic sys_rst,
  input  wire logic start,
  input  wire fxp_t dividend,
  input  wire fxp_t divisor,
  output logic      done,
  output fxp_t      quot
);

  logic [FXP_W-1:0] dvd_mag;
  logic [FXP_W-1:0] dvs_mag;

  logic                  busy;
  logic [STEP_CNT_W-1:0] step_cnt;
  logic                  neg_q;
  logic [FXP_W-1:0]      dvs_q;
  logic [FXP_W-1:0]      rem_q;
  logic [DIV_STEPS-1:0]  num_q;  // numerator shifts out, quotient shifts in

  logic [FXP_W:0]       trial;
  logic                 take;
  logic [FXP_W:0]       rem_next;
  logic [DIV_STEPS-1:0] num_next;

  assign dvd_mag = dividend[FXP_W-1] ? unsigned'(-dividend) : unsigned'(dividend);
  assign dvs_mag = divisor[FXP_W-1] ? unsigned'(-divisor) : unsigned'(divisor);

  // one restoring step
  assign trial    = {rem_q, num_q[DIV_STEPS-1]};
  assign take     = trial >= {1'b0, dvs_q};
  assign rem_next = take ? trial - {1'b0, dvs_q} : trial;
  assign num_next = {num_q[DIV_STEPS-2:0], take};

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      busy     <= 1'b0;
      step_cnt <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy     <= 1'b1;
        step_cnt <= '0;
      end else if (busy) begin
        step_cnt <= step_cnt + 1'b1;
        if (step_cnt == STEP_CNT_W'(DIV_STEPS - 1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      neg_q <= dividend[FXP_W-1] ^ divisor[FXP_W-1];
      dvs_q <= dvs_mag;
      rem_q <= '0;
      num_q <= {dvd_mag, {FRAC_BITS{1'b0}}};  // |a| * 2^19
    end else if (busy) begin
      rem_q <= rem_next[FXP_W-1:0];
      num_q <= num_next;
      if (step_cnt == STEP_CNT_W'(DIV_STEPS - 1)) begin
        quot <= neg_q ? -fxp_t'(num_next[FXP_W-1:0]) : fxp_t'(num_next[FXP_W-1:0]);
      end
    end
  end

  a_no_restart: assert property (@(posedge clk) disable iff (sys_rst)
    start |-> !busy)
    else $error("divider restarted mid division");

endmodule

`default_nettype wire

// File: hw/inv_collector.sv
`default_nettype none

module inv_collector import slam_cache_pkg::*; (
  input  wire logic               clk,
  input  wire logic               sys_rst,
  input  wire logic [NUM_DIV-1:0] div_done,
  input  wire fxp_t               div_quot [NUM_DIV],
  output fxp_t                    inv_11,
  output fxp_t                    inv_12,
  output fxp_t                    inv_22,
  output logic                    done_inv
);

  fxp_t               inv_q [NUM_DIV];
  logic [NUM_DIV-1:0] got;
  logic [NUM_DIV-1:0] pend_base;
  logic [NUM_DIV-1:0] pend_next;

  // a finished round restarts on its first done
  assign pend_base = (&got) ? '0 : got;
  assign pend_next = pend_base | div_done;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      got      <= '0;
      done_inv <= 1'b0;
      for (int i = 0; i < NUM_DIV; i++) begin
        inv_q[i] <= '0;
      end
    end else begin
      done_inv <= (|div_done) && (&pend_next);
      if (|div_done) begin
        got <= pend_next;
      end
      for (int i = 0; i < NUM_DIV; i++) begin
        if (div_done[i]) begin
          inv_q[i] <= div_quot[i];
        end
      end
    end
  end

  assign inv_11 = inv_q[0];
  assign inv_12 = inv_q[1];
  assign inv_22 = inv_q[2];

  a_done_pulse: assert property (@(posedge clk) disable iff (sys_rst)
    done_inv |=> !done_inv)
    else $error("done_inv held longer than one cycle");

endmodule

`default_nettype wire

// File: hw/cache_din_mux.sv
`default_nettype none

module cache_din_mux import slam_cache_pkg::*; (
  input  wire logic       clk,
  input  wire logic       sys_rst,
  input  wire cache_sel_t cache_sel,
  input  wire seq_cnt_t   seq_cnt,
  input  wire lane_vec_t  tb_doutb,
  input  wire lane_vec_t  c_din,
  input  wire fxp_t       fxi_13,
  input  wire fxp_t       fxi_23,
  input  wire fxp_t       hxi_11,
  input  wire fxp_t       hxi_12,
  input  wire fxp_t       hxi_21,
  input  wire fxp_t       hxi_22,
  input  wire fxp_t       hz_11,
  input  wire fxp_t       hz_12,
  input  wire fxp_t       hz_21,
  input  wire fxp_t       hz_22,
  input  wire fxp_t       vt_1,
  input  wire fxp_t       vt_2,
  input  wire fxp_t       inv_11,
  input  wire fxp_t       inv_12,
  input  wire fxp_t       inv_22,
  output lane_vec_t       cache_din
);

  fxp_t      lane [NUM_LANES];
  logic      copy_word;
  lane_vec_t din_next;

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane[i] = '0;
    end
    copy_word = 1'b0;
    case (cache_sel)
      wr_cov_ht, wr_h_lv_h: copy_word = 1'b1;
      wr_nl_prd: begin  // F_xi with identity
        case (seq_cnt)
          5'd1: lane[0] = FXP_ONE;
          5'd3: begin
            lane[0] = fxi_13;
            lane[1] = FXP_ONE;
          end
          5'd4: lane[1] = fxi_23;
          5'd5: lane[2] = FXP_ONE;
          default: ;
        endcase
      end
      wr_nl_upd: begin
        case (seq_cnt)
          5'd1: lane[0] = hxi_11;
          5'd2: begin
            lane[0] = hxi_12;
            lane[1] = hxi_21;
          end
          5'd3: lane[1] = hxi_22;
          5'd4: begin
            lane[0] = hz_11;
            lane[1] = -FXP_ONE;
          end
          5'd5: begin
            lane[0] = hz_12;
            lane[1] = hz_21;
          end
          5'd6: begin
            lane[0] = vt_1;
            lane[1] = hz_22;
          end
          5'd7: lane[0] = vt_2;
          default: ;
        endcase
      end
      wr_inv: begin  // symmetric S inverse
        case (seq_cnt)
          5'd1: lane[0] = inv_11;
          5'd2: begin
            lane[0] = inv_12;
            lane[1] = inv_12;
          end
          5'd3: lane[1] = inv_22;
          default: ;
        endcase
      end
      wr_chi: begin
        if (seq_cnt == 5'd10 || seq_cnt == 5'd12) begin
          lane[0] = c_din[0 +: FXP_W];
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      din_next[i*FXP_W +: FXP_W] = lane[i];
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      cache_din <= '0;
    end else begin
      cache_din <= copy_word ? tb_doutb : din_next;
    end
  end

endmodule

`default_nettype wire

// File: hw/slam_cache_din_map.sv
`default_nettype none

module slam_cache_din_map import slam_cache_pkg::*; (
  input  wire logic       clk,
  input  wire logic       sys_rst,
  input  wire cache_sel_t cache_sel,
  input  wire seq_cnt_t   seq_cnt,
  input  wire lane_vec_t  tb_doutb,
  input  wire lane_vec_t  c_din,
  input  wire fxp_t       fxi_13,
  input  wire fxp_t       fxi_23,
  input  wire fxp_t       hxi_11,
  input  wire fxp_t       hxi_12,
  input  wire fxp_t       hxi_21,
  input  wire fxp_t       hxi_22,
  input  wire fxp_t       hz_11,
  input  wire fxp_t       hz_12,
  input  wire fxp_t       hz_21,
  input  wire fxp_t       hz_22,
  input  wire fxp_t       vt_1,
  input  wire fxp_t       vt_2,
  input  wire logic       init_inv,
  output logic            done_inv,
  output lane_vec_t       cache_din
);

  logic               div_start;
  fxp_t               div_dividend [NUM_DIV];
  fxp_t               div_divisor;
  logic [NUM_DIV-1:0] div_done;
  fxp_t               div_quot [NUM_DIV];
  fxp_t               inv_11;
  fxp_t               inv_12;
  fxp_t               inv_22;

  innov_cov_reader innov_cov_reader_inst (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .init_inv     (init_inv),
    .c_din        (c_din),
    .div_start    (div_start),
    .div_dividend (div_dividend),
    .div_divisor  (div_divisor)
  );

  // three entries divided in parallel
  for (genvar i = 0; i < NUM_DIV; i++) begin : g_div
    fxp_divider fxp_divider_inst (
      .clk      (clk),
      .sys_rst  (sys_rst),
      .start    (div_start),
      .dividend (div_dividend[i]),
      .divisor  (div_divisor),
      .done     (div_done[i]),
      .quot     (div_quot[i])
    );
  end

  inv_collector inv_collector_inst (
    .clk      (clk),
    .sys_rst  (sys_rst),
    .div_done (div_done),
    .div_quot (div_quot),
    .inv_11   (inv_11),
    .inv_12   (inv_12),
    .inv_22   (inv_22),
    .done_inv (done_inv)
  );

  cache_din_mux cache_din_mux_inst (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .cache_sel (cache_sel),
    .seq_cnt   (seq_cnt),
    .tb_doutb  (tb_doutb),
    .c_din     (c_din),
    .fxi_13    (fxi_13),
    .fxi_23    (fxi_23),
    .hxi_11    (hxi_11),
    .hxi_12    (hxi_12),
    .hxi_21    (hxi_21),
    .hxi_22    (hxi_22),
    .hz_11     (hz_11),
    .hz_12     (hz_12),
    .hz_21     (hz_21),
    .hz_22     (hz_22),
    .vt_1      (vt_1),
    .vt_2      (vt_2),
    .inv_11    (inv_11),
    .inv_12    (inv_12),
    .inv_22    (inv_22),
    .cache_din (cache_din)
  );

endmodule

`default_nettype wire

// File: testbench/tb_slam_cache_din_map.sv
`default_nettype none

module tb_slam_cache_din_map import slam_cache_pkg::*; ();

  localparam int DIV_LAT     = DIV_STEPS + 12;  // start to done_inv, with slack
  localparam int TEST_CYCLES = 230;
  localparam int MAX_CYCLES  = TEST_CYCLES + 4 * DIV_LAT;

  logic       clk = 1'b0;
  logic       sys_rst;
  cache_sel_t cache_sel;
  seq_cnt_t   seq_cnt;
  lane_vec_t  tb_doutb;
  lane_vec_t  c_din;
  fxp_t       fxi_13, fxi_23;
  fxp_t       hxi_11, hxi_12, hxi_21, hxi_22;
  fxp_t       hz_11, hz_12, hz_21, hz_22;
  fxp_t       vt_1, vt_2;
  logic       init_inv;
  logic       done_inv;
  lane_vec_t  cache_din;

  int          errors = 0;
  logic [31:0] lcg_state = 32'hb256d4e6;
  lane_vec_t   last_inv_w1;
  lane_vec_t   last_inv_w3;
  bit          have_last = 1'b0;

  slam_cache_din_map slam_cache_din_map_inst (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .cache_sel (cache_sel),
    .seq_cnt   (seq_cnt),
    .tb_doutb  (tb_doutb),
    .c_din     (c_din),
    .fxi_13    (fxi_13),
    .fxi_23    (fxi_23),
    .hxi_11    (hxi_11),
    .hxi_12    (hxi_12),
    .hxi_21    (hxi_21),
    .hxi_22    (hxi_22),
    .hz_11     (hz_11),
    .hz_12     (hz_12),
    .hz_21     (hz_21),
    .hz_22     (hz_22),
    .vt_1      (vt_1),
    .vt_2      (vt_2),
    .init_inv  (init_inv),
    .done_inv  (done_inv),
    .cache_din (cache_din)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic lane_vec_t pack_lanes(fxp_t l0, fxp_t l1, fxp_t l2, fxp_t l3);
    return {l3, l2, l1, l0};
  endfunction

  // full product, drop 19 fraction bits, keep 32
  function automatic fxp_t mul_q19(fxp_t a, fxp_t b);
    logic signed [63:0] p;
    p = a * b;
    return p[FRAC_BITS +: 32];
  endfunction

  function automatic fxp_t div_q19(fxp_t a, fxp_t b);
    logic [31:0] ma;
    logic [31:0] mb;
    logic [63:0] num;
    logic [63:0] q;
    fxp_t        r;
    ma  = a[31] ? -a : a;
    mb  = b[31] ? -b : b;
    num = {13'b0, ma, 19'b0};
    q   = num / {32'b0, mb};
    r   = q[31:0];  // wraps like the hardware
    return (a[31] ^ b[31]) ? -r : r;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
    if (exp !== act) begin
      errors++;
      $display("[FAIL] time %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic reset_test();
    check("cache_din after reset", '0, cache_din);
    check("done_inv after reset", '0, done_inv);
    tb_doutb  = {next_rand(), next_rand(), next_rand(), next_rand()};
    cache_sel = idle;
    seq_cnt   = 5'd3;
    step();
    check("cache_din idle", '0, cache_din);
    cache_sel = cache_sel_t'(4'd13);  // unused code
    step();
    check("cache_din code 13", '0, cache_din);
  endtask

  task automatic predict_test();
    lane_vec_t exp;
    fxi_13    = fxp_t'(next_rand());
    fxi_23    = fxp_t'(next_rand());
    cache_sel = wr_nl_prd;
    for (int s = 0; s <= 8; s++) begin
      seq_cnt = seq_cnt_t'(s);
      step();
      case (s)
        1: exp = pack_lanes(FXP_ONE, 0, 0, 0);
        3: exp = pack_lanes(fxi_13, FXP_ONE, 0, 0);
        4: exp = pack_lanes(0, fxi_23, 0, 0);
        5: exp = pack_lanes(0, 0, FXP_ONE, 0);
        default: exp = '0;
      endcase
      check($sformatf("cache_din prd seq %0d", s), exp, cache_din);
    end
  endtask

  task automatic update_test();
    lane_vec_t exp;
    hxi_11 = fxp_t'(next_rand());
    hxi_12 = fxp_t'(next_rand());
    hxi_21 = fxp_t'(next_rand());
    hxi_22 = fxp_t'(next_rand());
    hz_11  = fxp_t'(next_rand());
    hz_12  = fxp_t'(next_rand());
    hz_21  = fxp_t'(next_rand());
    hz_22  = fxp_t'(next_rand());
    vt_1   = fxp_t'(next_rand());
    vt_2   = fxp_t'(next_rand());
    cache_sel = wr_nl_upd;
    for (int s = 0; s <= 9; s++) begin
      seq_cnt = seq_cnt_t'(s);
      step();
      case (s)
        1: exp = pack_lanes(hxi_11, 0, 0, 0);
        2: exp = pack_lanes(hxi_12, hxi_21, 0, 0);
        3: exp = pack_lanes(0, hxi_22, 0, 0);
        4: exp = pack_lanes(hz_11, -FXP_ONE, 0, 0);
        5: exp = pack_lanes(hz_12, hz_21, 0, 0);
        6: exp = pack_lanes(vt_1, hz_22, 0, 0);
        7: exp = pack_lanes(vt_2, 0, 0, 0);
        default: exp = '0;
      endcase
      check($sformatf("cache_din upd seq %0d", s), exp, cache_din);
    end
  endtask

  task automatic copy_test(input cache_sel_t mode);
    cache_sel = mode;
    for (int i = 0; i < 4; i++) begin
      tb_doutb = {next_rand(), next_rand(), next_rand(), next_rand()};
      seq_cnt  = seq_cnt_t'(next_rand());
      step();
      check($sformatf("cache_din copy mode %0d", mode), tb_doutb, cache_din);
    end
  endtask

  task automatic chi_test();
    lane_vec_t exp;
    cache_sel = wr_chi;
    for (int s = 0; s < 16; s++) begin
      c_din   = {next_rand(), next_rand(), next_rand(), next_rand()};
      seq_cnt = seq_cnt_t'(s);
      step();
      exp = (s == 10 || s == 12) ? {96'b0, c_din[31:0]} : '0;
      check($sformatf("cache_din chi seq %0d", s), exp, cache_din);
    end
  endtask

  task automatic inverse_test();
    logic [31:0] r;
    fxp_t        s11_raw, s21, s22_raw;
    fxp_t        s11, s22, det;
    fxp_t        e11, e12, e22;
    lane_vec_t   w1, w3;
    int          n;
    // diagonal in [1,4) before noise, off-diagonal within +-0.5
    r       = next_rand();
    s11_raw = FXP_ONE + fxp_t'(r % 32'd1572864);
    r       = next_rand();
    s22_raw = FXP_ONE + fxp_t'(r % 32'd1572864);
    r       = next_rand();
    s21     = fxp_t'(r % 32'd524288) - 32'sd262144;
    s11 = s11_raw + FXP_ONE;
    s22 = s22_raw + FXP_ONE;
    det = mul_q19(s11, s22) - mul_q19(s21, s21);
    e11 = div_q19(s22, det);
    e12 = div_q19(-s21, det);
    e22 = div_q19(s11, det);

    cache_sel = idle;
    seq_cnt   = '0;
    init_inv  = 1'b1;
    step();  // E0 has passed
    init_inv = 1'b0;
    step();
    c_din = pack_lanes(s11_raw, s21, 0, 0);  // lane 0 at E0+2, lane 1 at E0+3
    step();
    step();
    c_din = pack_lanes(0, s22_raw, 0, 0);  // lane 1 at E0+5

    n = 0;
    while (!done_inv && n < 2 * DIV_LAT) begin
      step();
      n++;
    end
    if (!done_inv) begin
      errors++;
      $display("done_inv did not arrive within %0d cycles of the inverse start", 2 * DIV_LAT);
    end
    step();
    check("done_inv pulse width", '0, done_inv);

    cache_sel = wr_inv;
    seq_cnt   = 5'd1;
    step();
    w1 = cache_din;
    check("cache_din inv seq 1", pack_lanes(e11, 0, 0, 0), cache_din);
    seq_cnt = 5'd2;
    step();
    check("cache_din inv seq 2", pack_lanes(e12, e12, 0, 0), cache_din);
    seq_cnt = 5'd3;
    step();
    w3 = cache_din;
    check("cache_din inv seq 3", pack_lanes(0, e22, 0, 0), cache_din);
    cache_sel = idle;
    seq_cnt   = '0;

    if (have_last && w1 == last_inv_w1 && w3 == last_inv_w3) begin
      errors++;
      $display("inverse values did not change after a new init_inv");
    end
    last_inv_w1 = w1;
    last_inv_w3 = w3;
    have_last   = 1'b1;
  endtask

  // watchdog
  initial begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("test failed");
    $finish;
  end

  initial begin
    sys_rst   = 1'b1;
    init_inv  = 1'b0;
    cache_sel = idle;
    seq_cnt   = '0;
    tb_doutb  = '0;
    c_din     = '0;
    fxi_13    = '0;
    fxi_23    = '0;
    hxi_11    = '0;
    hxi_12    = '0;
    hxi_21    = '0;
    hxi_22    = '0;
    hz_11     = '0;
    hz_12     = '0;
    hz_21     = '0;
    hz_22     = '0;
    vt_1      = '0;
    vt_2      = '0;
    repeat (16) @(posedge clk);
    #1;
    sys_rst = 1'b0;

    reset_test();
    predict_test();
    update_test();
    copy_test(wr_cov_ht);
    copy_test(wr_h_lv_h);
    chi_test();
    inverse_test();
    inverse_test();  // second S, values must move

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: slam_cache_din_map.f
hw/slam_cache_pkg.sv
hw/innov_cov_reader.sv
hw/fxp_divider.sv
hw/inv_collector.sv
hw/cache_din_mux.sv
hw/slam_cache_din_map.sv
testbench/tb_slam_cache_din_map.sv
